//--- src/rv_pkg.sv
package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    localparam word_t NOP_INSN = 32'h0000_0013;  // addi x0, x0, 0

    // Fence and system decode as nops
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_FENCE  = 7'b0001111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    // Instruction views, all sharing the low fields
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_e    opcode;
    } insn_r_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        opcode_e     opcode;
    } insn_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;      // imm[12|10:5] for branches
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;      // imm[4:1|11]
        opcode_e    opcode;
    } insn_sb_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_addr_t   rd;
        opcode_e     opcode;
    } insn_uj_t;

    typedef union packed {
        insn_r_t  r;
        insn_i_t  i;
        insn_sb_t sb;
        insn_uj_t uj;
    } insn_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B
    } alu_op_e;

    // BR_NONE must stay zero so an all-zero stage is a bubble
    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_ALWAYS
    } branch_e;

    typedef enum logic {A_REG, A_PC}  a_sel_e;
    typedef enum logic {B_REG, B_IMM} b_sel_e;

    typedef struct packed {
        word_t pc;
        insn_t insn;
    } if_id_t;

    typedef struct packed {
        word_t     pc;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        reg_addr_t rd;           // x0 means no write
        alu_op_e   alu_op;
        a_sel_e    a_sel;
        b_sel_e    b_sel;
        branch_e   branch;
        logic      jump_reg;     // JALR target from rs1
        logic      link;         // Write pc + 4
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } result_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

//--- src/fetch_stage.sv
module fetch_stage #(
    parameter rv_pkg::word_t RESET_PC = 32'h0100_0000
) (
    input  logic              clock,
    input  logic              reset,
    input  rv_pkg::redirect_t redirect,
    input  rv_pkg::word_t     fetch_insn,
    output rv_pkg::word_t     fetch_pc,
    output rv_pkg::if_id_t    if_id
);
    import rv_pkg::*;

    word_t pc;
    word_t pc_plus4;
    word_t next_pc;

    assign pc_plus4 = pc + word_t'(4);
    assign next_pc  = redirect.taken ? redirect.target : pc_plus4;
    assign fetch_pc = pc;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    // Word arriving this cycle is already in the shadow of a redirect
    always_ff @(posedge clock) begin
        if (reset || redirect.taken) begin
            if_id.pc   <= '0;
            if_id.insn <= NOP_INSN;
        end else begin
            if_id.pc   <= pc;
            if_id.insn <= fetch_insn;
        end
    end

endmodule

//--- src/decode_stage.sv
module decode_stage (
    input  logic                clock,
    input  logic                reset,
    input  rv_pkg::if_id_t      if_id,
    input  rv_pkg::redirect_t   redirect,
    output rv_pkg::reg_addr_t   rs1_addr,
    output rv_pkg::reg_addr_t   rs2_addr,
    input  rv_pkg::word_t       rs1_data,
    input  rv_pkg::word_t       rs2_data,
    output rv_pkg::id_ex_t      id_ex
);
    import rv_pkg::*;

    insn_t  insn;
    word_t  imm_i;
    word_t  imm_b;
    word_t  imm_u;
    word_t  imm_j;
    word_t  imm_shamt;
    id_ex_t next;

    // Shared by register and immediate forms; alt is instruction bit 30
    function automatic alu_op_e alu_decode(logic [2:0] funct3, logic alt, logic is_reg);
        case (funct3)
            3'b000:  return (alt && is_reg) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign insn = if_id.insn;

    assign imm_i = {{20{insn.i.imm[11]}}, insn.i.imm};
    assign imm_b = {{19{insn.sb.imm_hi[6]}}, insn.sb.imm_hi[6], insn.sb.imm_lo[0],
                    insn.sb.imm_hi[5:0], insn.sb.imm_lo[4:1], 1'b0};
    assign imm_u = {insn.uj.imm, 12'b0};
    assign imm_j = {{12{insn.uj.imm[19]}}, insn.uj.imm[7:0], insn.uj.imm[8],
                    insn.uj.imm[18:9], 1'b0};
    assign imm_shamt = {27'b0, insn.r.rs2};

    always_comb begin
        next    = '0;
        next.pc = if_id.pc;
        case (insn.r.opcode)
            OP_REG: begin
                next.rs1    = insn.r.rs1;
                next.rs2    = insn.r.rs2;
                next.rd     = insn.r.rd;
                next.alu_op = alu_decode(insn.r.funct3, insn.r.funct7[5], 1'b1);
            end
            OP_IMM: begin
                next.rs1    = insn.i.rs1;
                next.rd     = insn.i.rd;
                next.b_sel  = B_IMM;
                next.alu_op = alu_decode(insn.i.funct3, insn.r.funct7[5], 1'b0);
                next.imm    = (insn.i.funct3[1:0] == 2'b01) ? imm_shamt : imm_i;
            end
            OP_LUI: begin
                next.rd     = insn.uj.rd;
                next.b_sel  = B_IMM;
                next.alu_op = ALU_PASS_B;
                next.imm    = imm_u;
            end
            OP_AUIPC: begin
                next.rd    = insn.uj.rd;
                next.a_sel = A_PC;
                next.b_sel = B_IMM;
                next.imm   = imm_u;
            end
            OP_JAL: begin
                next.rd     = insn.uj.rd;
                next.imm    = imm_j;
                next.branch = BR_ALWAYS;
                next.link   = 1'b1;
            end
            OP_JALR: begin
                next.rs1      = insn.i.rs1;
                next.rd       = insn.i.rd;
                next.imm      = imm_i;
                next.branch   = BR_ALWAYS;
                next.jump_reg = 1'b1;
                next.link     = 1'b1;
            end
            OP_BRANCH: begin
                next.rs1 = insn.sb.rs1;
                next.rs2 = insn.sb.rs2;
                next.imm = imm_b;
                case (insn.sb.funct3)
                    3'b000:  next.branch = BR_EQ;
                    3'b001:  next.branch = BR_NE;
                    3'b100:  next.branch = BR_LT;
                    3'b101:  next.branch = BR_GE;
                    3'b110:  next.branch = BR_LTU;
                    3'b111:  next.branch = BR_GEU;
                    default: next.branch = BR_NONE;
                endcase
            end
            OP_FENCE, OP_SYSTEM: ;   // No effect in this core
            default: ;               // Unknown, no write
        endcase
    end

    assign rs1_addr = next.rs1;
    assign rs2_addr = next.rs2;

    always_ff @(posedge clock) begin
        if (reset || redirect.taken) begin
            id_ex <= '0;
        end else begin
            id_ex          <= next;
            id_ex.rs1_data <= rs1_data;
            id_ex.rs2_data <= rs2_data;
        end
    end

    // Both younger stages are squashed one cycle after a redirect
    assert property (@(posedge clock) disable iff (reset)
        redirect.taken |=> !redirect.taken && (if_id.insn == NOP_INSN));

endmodule

//--- src/register_file.sv
module register_file (
    input  logic              clock,
    input  logic              reset,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data,
    input  rv_pkg::result_t   wb
);
    import rv_pkg::*;

    word_t regs [1:31];   // x0 is not stored

    // New data wins over the stored copy during a write
    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb.valid && wb.rd == addr) begin
            return wb.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    always_ff @(posedge clock) begin
        if (!reset && wb.valid) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assert property (@(posedge clock) disable iff (reset) wb.valid |-> wb.rd != '0);

endmodule

//--- src/execute_stage.sv
module execute_stage (
    input  rv_pkg::id_ex_t    id_ex,
    input  rv_pkg::result_t   mem_fwd,
    input  rv_pkg::result_t   wb,
    output rv_pkg::result_t   ex_result,
    output rv_pkg::redirect_t redirect
);
    import rv_pkg::*;

    word_t rs1_val;
    word_t rs2_val;
    word_t op_a;
    word_t op_b;
    word_t alu_out;
    word_t pc_plus4;
    word_t jump_base;
    word_t jump_sum;
    word_t target;
    logic  taken;

    // Youngest producer first, then writeback, then the register file value
    function automatic word_t forward(reg_addr_t addr, word_t rf_data,
                                      result_t near, result_t far);
        if (near.valid && near.rd == addr) begin
            return near.data;
        end
        if (far.valid && far.rd == addr) begin
            return far.data;
        end
        return rf_data;
    endfunction

    assign rs1_val = forward(id_ex.rs1, id_ex.rs1_data, mem_fwd, wb);
    assign rs2_val = forward(id_ex.rs2, id_ex.rs2_data, mem_fwd, wb);

    assign op_a = (id_ex.a_sel == A_PC)  ? id_ex.pc  : rs1_val;
    assign op_b = (id_ex.b_sel == B_IMM) ? id_ex.imm : rs2_val;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SLL:    alu_out = op_a << op_b[4:0];
            ALU_SRL:    alu_out = op_a >> op_b[4:0];
            ALU_SRA:    alu_out = word_t'($signed(op_a) >>> op_b[4:0]);
            ALU_SLT:    alu_out = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_out = word_t'(op_a < op_b);
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    // Branch compare on the forwarded register values
    always_comb begin
        case (id_ex.branch)
            BR_EQ:     taken = (rs1_val == rs2_val);
            BR_NE:     taken = (rs1_val != rs2_val);
            BR_LT:     taken = ($signed(rs1_val) <  $signed(rs2_val));
            BR_GE:     taken = ($signed(rs1_val) >= $signed(rs2_val));
            BR_LTU:    taken = (rs1_val <  rs2_val);
            BR_GEU:    taken = (rs1_val >= rs2_val);
            BR_ALWAYS: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    // One adder serves branches, JAL and JALR
    assign jump_base = id_ex.jump_reg ? rs1_val : id_ex.pc;
    assign jump_sum  = jump_base + id_ex.imm;
    assign target    = id_ex.jump_reg ? {jump_sum[XLEN-1:1], 1'b0} : jump_sum;

    assign redirect = '{taken: taken, target: target};

    assign pc_plus4 = id_ex.pc + word_t'(4);

    assign ex_result = '{
        valid: (id_ex.rd != '0),
        rd:    id_ex.rd,
        data:  id_ex.link ? pc_plus4 : alu_out
    };

    // Branch targets rely on the fetch PC and the decoded offset
    always_comb begin
        if (redirect.taken) begin
            assert (redirect.target[0] == 1'b0)
                else $error("redirect target %h has bit 0 set", redirect.target);
        end
    end

endmodule

//--- src/result_pipe.sv
module result_pipe (
    input  logic            clock,
    input  logic            reset,
    input  rv_pkg::result_t ex_result,
    output rv_pkg::result_t mem_fwd,
    output rv_pkg::result_t wb
);

    // EX/MEM stage, first forwarding source
    always_ff @(posedge clock) begin
        if (reset) begin
            mem_fwd <= '0;
        end else begin
            mem_fwd <= ex_result;
        end
    end

    // MEM/WB stage, drives the register write and retire
    always_ff @(posedge clock) begin
        if (reset) begin
            wb <= '0;
        end else begin
            wb <= mem_fwd;
        end
    end

    // Decode must have turned every x0 destination into no write
    assert property (@(posedge clock) disable iff (reset)
        ex_result.valid |-> ex_result.rd != '0);

endmodule

//--- src/rv_core.sv
module rv_core #(
    parameter rv_pkg::word_t RESET_PC = 32'h0100_0000
) (
    input  logic            clock,
    input  logic            reset,
    output rv_pkg::word_t   fetch_pc,
    input  rv_pkg::word_t   fetch_insn,
    output rv_pkg::result_t retire
);
    import rv_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    redirect_t redirect;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    result_t   ex_result;
    result_t   mem_fwd;
    result_t   wb;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clock      (clock),
        .reset      (reset),
        .redirect   (redirect),
        .fetch_insn (fetch_insn),
        .fetch_pc   (fetch_pc),
        .if_id      (if_id)
    );

    decode_stage u_decode (
        .clock    (clock),
        .reset    (reset),
        .if_id    (if_id),
        .redirect (redirect),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .id_ex    (id_ex)
    );

    register_file u_regs (
        .clock    (clock),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    execute_stage u_execute (
        .id_ex     (id_ex),
        .mem_fwd   (mem_fwd),
        .wb        (wb),
        .ex_result (ex_result),
        .redirect  (redirect)
    );

    result_pipe u_results (
        .clock     (clock),
        .reset     (reset),
        .ex_result (ex_result),
        .mem_fwd   (mem_fwd),
        .wb        (wb)
    );

    assign retire = wb;   // One strobe per register write

endmodule

//--- tests/rv_core_tb.sv
module rv_core_tb;
    import rv_pkg::*;

    localparam word_t RESET_PC = 32'h0100_0000;

    typedef struct packed {
        word_t      insn;
        logic       retires;
        reg_addr_t  rd;
        word_t      value;
        logic       jumps;    // Taken branch or jump
        logic [7:0] target;   // Row index of the jump target
    } row_t;

    logic    clock;
    logic    reset;
    word_t   fetch_pc;
    word_t   fetch_insn;
    result_t retire;

    row_t  rows [$];
    row_t  expected_q [$];
    int    ago [3];           // Rows fetched 1, 2 and 3 cycles back
    word_t expected_pc;
    int    cycle_count;
    int    cycle_limit;

    rv_core #(
        .RESET_PC (RESET_PC)
    ) u_dut (
        .clock      (clock),
        .reset      (reset),
        .fetch_pc   (fetch_pc),
        .fetch_insn (fetch_insn),
        .retire     (retire)
    );

    always #50 clock = ~clock;

    function automatic word_t r_type(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OP_REG};
    endfunction

    function automatic word_t i_type(int imm, int rs1, logic [2:0] f3, int rd, logic [6:0] op);
        return {12'(imm), 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic word_t b_type(int imm, int rs2, int rs1, logic [2:0] f3);
        logic [12:0] off;
        off = 13'(imm);
        return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic word_t u_type(int imm, int rd, logic [6:0] op);
        return {20'(imm), 5'(rd), op};
    endfunction

    function automatic word_t j_type(int imm, int rd);
        logic [20:0] off;
        off = 21'(imm);
        return {off[20], off[10:1], off[11], off[19:12], 5'(rd), OP_JAL};
    endfunction

    // An rd of 0 marks a row that never retires
    task automatic add_row(word_t insn, int rd, word_t value, int target);
        rows.push_back('{insn: insn, retires: (rd != 0), rd: 5'(rd), value: value,
                         jumps: (target >= 0), target: 8'(target)});
    endtask

    task automatic load_program();
        add_row(i_type(5, 0, 3'b000, 1, OP_IMM), 1, 32'h0000_0005, -1);
        add_row(i_type(-3, 0, 3'b000, 2, OP_IMM), 2, 32'hFFFF_FFFD, -1);
        add_row(r_type(7'h00, 2, 1, 3'b000, 3), 3, 32'h0000_0002, -1);    // Distance 1 and 2
        add_row(r_type(7'h20, 1, 2, 3'b000, 4), 4, 32'hFFFF_FFF8, -1);    // x1 at distance 3
        add_row(i_type('h402, 4, 3'b101, 5, OP_IMM), 5, 32'hFFFF_FFFE, -1);  // srai
        add_row(r_type(7'h20, 1, 4, 3'b101, 6), 6, 32'hFFFF_FFFF, -1);    // sra
        add_row(r_type(7'h00, 1, 4, 3'b101, 7), 7, 32'h07FF_FFFF, -1);    // srl
        add_row(i_type(3, 1, 3'b001, 8, OP_IMM), 8, 32'h0000_0028, -1);   // slli
        add_row(r_type(7'h00, 1, 2, 3'b010, 9), 9, 32'h0000_0001, -1);    // slt
        add_row(r_type(7'h00, 1, 2, 3'b011, 10), 10, 32'h0000_0000, -1);  // sltu
        add_row(i_type(-2, 2, 3'b010, 11, OP_IMM), 11, 32'h0000_0001, -1);
        add_row(r_type(7'h00, 2, 1, 3'b100, 12), 12, 32'hFFFF_FFF8, -1);
        add_row(r_type(7'h00, 2, 1, 3'b110, 13), 13, 32'hFFFF_FFFD, -1);
        add_row(r_type(7'h00, 2, 1, 3'b111, 14), 14, 32'h0000_0005, -1);
        add_row(i_type('hF0, 2, 3'b111, 15, OP_IMM), 15, 32'h0000_00F0, -1);
        add_row(i_type(-16, 1, 3'b110, 16, OP_IMM), 16, 32'hFFFF_FFF5, -1);
        add_row(u_type('h12345, 17, OP_LUI), 17, 32'h1234_5000, -1);
        add_row(i_type('h678, 17, 3'b000, 17, OP_IMM), 17, 32'h1234_5678, -1);
        add_row(u_type(1, 18, OP_AUIPC), 18, 32'h0100_1048, -1);
        add_row(u_type(0, 19, OP_AUIPC), 19, 32'h0100_004C, -1);
        // Each kind not taken, then taken over two shadow rows
        add_row(b_type(12, 3, 1, 3'b000), 0, '0, -1);
        add_row(i_type(1, 0, 3'b000, 20, OP_IMM), 20, 32'h0000_0001, -1);
        add_row(b_type(12, 1, 1, 3'b000), 0, '0, 25);
        add_row(i_type(99, 0, 3'b000, 20, OP_IMM), 0, '0, -1);
        add_row(i_type(98, 0, 3'b000, 21, OP_IMM), 0, '0, -1);
        add_row(b_type(12, 1, 1, 3'b001), 0, '0, -1);
        add_row(i_type(2, 0, 3'b000, 21, OP_IMM), 21, 32'h0000_0002, -1);
        add_row(b_type(12, 2, 1, 3'b001), 0, '0, 30);
        add_row(i_type(99, 0, 3'b000, 26, OP_IMM), 0, '0, -1);
        add_row(i_type(98, 0, 3'b000, 27, OP_IMM), 0, '0, -1);
        add_row(b_type(12, 2, 1, 3'b100), 0, '0, -1);
        add_row(i_type(3, 0, 3'b000, 22, OP_IMM), 22, 32'h0000_0003, -1);
        add_row(b_type(12, 1, 2, 3'b100), 0, '0, 35);
        add_row(i_type(99, 0, 3'b000, 26, OP_IMM), 0, '0, -1);
        add_row(i_type(98, 0, 3'b000, 27, OP_IMM), 0, '0, -1);
        add_row(b_type(12, 1, 2, 3'b101), 0, '0, -1);
        add_row(i_type(4, 0, 3'b000, 23, OP_IMM), 23, 32'h0000_0004, -1);
        add_row(b_type(12, 2, 1, 3'b101), 0, '0, 40);
        add_row(i_type(99, 0, 3'b000, 26, OP_IMM), 0, '0, -1);
        add_row(i_type(98, 0, 3'b000, 27, OP_IMM), 0, '0, -1);
        add_row(b_type(12, 1, 2, 3'b110), 0, '0, -1);
        add_row(i_type(5, 0, 3'b000, 24, OP_IMM), 24, 32'h0000_0005, -1);
        add_row(b_type(12, 2, 1, 3'b110), 0, '0, 45);
        add_row(i_type(99, 0, 3'b000, 26, OP_IMM), 0, '0, -1);
        add_row(i_type(98, 0, 3'b000, 27, OP_IMM), 0, '0, -1);
        add_row(b_type(12, 2, 1, 3'b111), 0, '0, -1);
        add_row(i_type(6, 0, 3'b000, 25, OP_IMM), 25, 32'h0000_0006, -1);
        add_row(b_type(12, 1, 2, 3'b111), 0, '0, 50);
        add_row(i_type(99, 0, 3'b000, 26, OP_IMM), 0, '0, -1);
        add_row(i_type(98, 0, 3'b000, 27, OP_IMM), 0, '0, -1);
        add_row(j_type(12, 30), 30, 32'h0100_00CC, 53);
        add_row(i_type(99, 0, 3'b000, 26, OP_IMM), 0, '0, -1);
        add_row(i_type(98, 0, 3'b000, 27, OP_IMM), 0, '0, -1);
        add_row(i_type(149, 19, 3'b000, 31, OP_JALR), 31, 32'h0100_00D8, 56);  // Odd sum
        add_row(i_type(99, 0, 3'b000, 26, OP_IMM), 0, '0, -1);
        add_row(i_type(98, 0, 3'b000, 27, OP_IMM), 0, '0, -1);
        add_row(r_type(7'h00, 31, 30, 3'b000, 1), 1, 32'h0200_01A4, -1);
        add_row(NOP_INSN, 0, '0, -1);
    endtask

    task automatic fail_run(string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(string name, word_t got, word_t want);
        assert (got === want)
            else fail_run($sformatf("CHECK FAILED at time %0t: %s is %h, expected %h",
                                    $time, name, got, want));
    endtask

    // One cycle of ROM service, PC tracking and retire checking
    task automatic step_cycle();
        word_t offset;
        int    row;
        row_t  want;
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            fail_run($sformatf("timeout after %0d cycles, %0d retires never arrived",
                               cycle_count, expected_q.size()));
        end
        check_value("fetch_pc", fetch_pc, expected_pc);
        offset = fetch_pc - RESET_PC;
        if (offset[1:0] == 2'b00 && offset < word_t'(4 * rows.size())) begin
            row        = int'(offset >> 2);
            fetch_insn = rows[row].insn;
        end else begin
            row        = -1;
            fetch_insn = NOP_INSN;   // Past the end of the program
        end
        if (retire.valid) begin
            if (expected_q.size() == 0) begin
                fail_run("a register write retired after the last expected row");
            end else begin
                want = expected_q.pop_front();
                check_value("retire.rd", word_t'(retire.rd), word_t'(want.rd));
                check_value("retire.data", retire.data, want.value);
            end
        end
        ago[2] = ago[1];
        ago[1] = ago[0];
        ago[0] = row;
        // Redirect from execute lands one cycle later
        if (ago[2] >= 0 && rows[ago[2]].jumps) begin
            expected_pc = RESET_PC + word_t'(4 * int'(rows[ago[2]].target));
        end else begin
            expected_pc = expected_pc + 32'd4;
        end
    endtask

    initial begin
        clock      = 1'b0;
        reset      = 1'b1;
        fetch_insn = NOP_INSN;
        load_program();
        foreach (rows[k]) begin
            if (rows[k].retires) begin
                expected_q.push_back(rows[k]);
            end
        end
        cycle_limit = 4 * rows.size() + 40;
        cycle_count = 0;
        expected_pc = RESET_PC;
        ago         = '{-1, -1, -1};
        repeat (8) begin
            @(posedge clock);
            #10;
            check_value("fetch_pc", fetch_pc, RESET_PC);
            check_value("retire.valid", word_t'(retire.valid), '0);
        end
        reset = 1'b0;
        step_cycle();
        while (expected_q.size() > 0) begin
            @(posedge clock);
            #10;
            step_cycle();
        end
        repeat (8) begin   // Drain, nothing else may retire
            @(posedge clock);
            #10;
            step_cycle();
        end
        $display("all tests passed");
        $finish;
    end

endmodule

//--- build.f
src/rv_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/register_file.sv
src/execute_stage.sv
src/result_pipe.sv
src/rv_core.sv
tests/rv_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "all tests passed"

clean:
	rm -rf $(OBJ_DIR)
